// ==== dv/spi_bridge_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_bridge_props
  import spi_bridge_pkg::*;
(
  input logic             pclk,
  input logic             SCKclock,
  input lane_mode_e       eve_quad,
  input lane_mode_e       fl_quad,
  input logic [LANES-1:0] eve_oe_o,
  input logic [LANES-1:0] fl_oe_o,
  input logic             eve_start8,
  input logic             eve_start16,
  input logic             eve_idle,
  input logic [1:0]       mux,
  input logic             host_miso_o
);

  // single mode leaves only miso as an input
  a_eve_single_oe: assert property (@(posedge pclk) disable iff (SCKclock)
    eve_quad == MODE_SINGLE |-> eve_oe_o == 4'b1101)
    else $error("eve oe wrong in single mode");

  a_fl_single_oe: assert property (@(posedge pclk) disable iff (SCKclock)
    fl_quad == MODE_SINGLE |-> fl_oe_o == 4'b1101)
    else $error("flash oe wrong in single mode");

  ////////////////////////////////////////////////////////////////////
  // busy never outlasts the fixed transfer length

  a_single8_len: assert property (@(posedge pclk) disable iff (SCKclock)
    $past(eve_start8, 17) && $past(eve_quad, 17) == MODE_SINGLE |-> eve_idle)
    else $error("single 8-bit transfer still busy");

  a_single16_len: assert property (@(posedge pclk) disable iff (SCKclock)
    $past(eve_start16, 33) && $past(eve_quad, 33) == MODE_SINGLE |-> eve_idle)
    else $error("single 16-bit transfer still busy");

  a_quad8_len: assert property (@(posedge pclk) disable iff (SCKclock)
    $past(eve_start8, 5) && $past(eve_quad, 5) == MODE_QUAD |-> eve_idle)
    else $error("quad 8-bit transfer still busy");

  a_quad16_len: assert property (@(posedge pclk) disable iff (SCKclock)
    $past(eve_start16, 9) && $past(eve_quad, 9) == MODE_QUAD |-> eve_idle)
    else $error("quad 16-bit transfer still busy");

  a_miso_off: assert property (@(posedge pclk) disable iff (SCKclock)
    mux == 2'b00 |-> !host_miso_o)  // nothing routed to the host
    else $error("host_miso active with mux clear");

endmodule

bind spi_bridge_top spi_bridge_props u_props (
  .pclk(pclk), .SCKclock(SCKclock), .eve_quad(eve_quad), .fl_quad(fl_quad),
  .eve_oe_o(eve_oe_o), .fl_oe_o(fl_oe_o), .eve_start8(eve_start8),
  .eve_start16(eve_start16), .eve_idle(eve_idle), .mux(mux), .host_miso_o(host_miso_o)
);

`default_nettype wire

// ==== dv/spi_bridge_stim.txt ====
// all fields hex: kind tgt quad dir wide data dev exp cycles
// kind 0 reset, 1 xfer, 2 random xfer, 3 host, 4 pins, 5 sysctl, 6 mux, f end
0 0 0 0 0 0000 00 0000 00
// single lane loopback on eve
1 0 0 0 0 12a5 22 12a5 10
1 0 0 0 1 12a5 22 a512 20
1 0 0 0 0 00ff 22 00ff 10
1 0 0 0 1 c3e1 22 e1c3 20
2 0 0 0 0 0000 22 0000 10
2 0 0 0 1 0000 22 0000 20
2 0 0 0 1 0000 22 0000 20
// flash single
1 1 0 0 0 1234 22 1234 10
1 1 0 0 1 5678 22 7856 20
// quad, lanes driven
1 0 1 0 0 3c5a 22 3c5a 04
1 0 1 0 1 3c5a 22 5a3c 08
2 0 1 0 0 0000 22 0000 04
// quad, lanes read from the device
1 0 1 1 0 3c5a 96 3c96 04
1 0 1 1 0 a0f0 e1 a0e1 04
2 0 1 1 0 0000 7b 0000 04
1 1 1 1 0 1234 c5 12c5 04
// back to single so idle mosi is low
1 1 0 0 0 1234 22 1234 10
1 0 0 0 0 00ff 22 00ff 10
// host passthrough
3 0 0 0 0 0005 22 0001 00
3 0 0 0 0 0002 00 0000 00
3 0 0 0 0 0003 22 0001 00
6 0 0 0 0 0000 22 0000 00
6 0 0 0 0 0002 22 0001 00
6 0 0 0 0 0000 22 0000 00
// static pins and readback
4 0 0 0 0 001f 00 000d 00
4 0 0 0 0 0022 22 0002 00
4 1 0 0 0 000a 22 000a 00
4 0 0 0 0 0020 00 0000 00
4 1 0 0 0 0020 00 0000 00
// power-down pin
5 0 0 0 0 0001 00 0001 00
5 0 0 0 0 0000 00 0000 00
f 0 0 0 0 0000 00 0000 00

// ==== dv/spi_bridge_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_bridge_tb
  import spi_bridge_pkg::*;
;

  localparam int REC_W     = 9;    // fields per stim record
  localparam int MAX_REC   = 64;
  localparam int POLL_MAX  = 100;  // cycles before a stat poll gives up
  localparam int RUN_LIMIT = 200000;

  logic                 pclk;
  logic                 SCKclock;
  logic [IO_ADDR_W-1:0] io_a_i;
  logic [IO_W-1:0]      io_wd_i;
  logic                 io_r_i;
  logic                 io_w_i;
  logic [IO_W-1:0]      io_rd_o;
  logic [LANES-1:0]     eve_io_i, eve_io_o, eve_oe_o;
  logic [LANES-1:0]     fl_io_i, fl_io_o, fl_oe_o;
  logic                 eve_cs_o, eve_sck_o, eve_pd_o;
  logic                 fl_cs_o, fl_sck_o;
  logic                 host_cs_i, host_sck_i, host_mosi_i, host_miso_o;

  logic [31:0] stim_mem [0:REC_W*MAX_REC-1];
  logic [31:0] lcg_state;
  logic        loop_en;   // device ties miso back to mosi
  logic [7:0]  dev_byte;  // device nibbles with the high one first
  logic        dev_idx;
  logic        dev_clr;
  logic [3:0]  dev_nib;

  spi_bridge_top UUT (
    .pclk(pclk), .SCKclock(SCKclock),
    .io_a_i(io_a_i), .io_wd_i(io_wd_i), .io_r_i(io_r_i), .io_w_i(io_w_i),
    .io_rd_o(io_rd_o),
    .eve_io_i(eve_io_i), .eve_cs_o(eve_cs_o), .eve_sck_o(eve_sck_o),
    .eve_io_o(eve_io_o), .eve_oe_o(eve_oe_o), .eve_pd_o(eve_pd_o),
    .fl_io_i(fl_io_i), .fl_cs_o(fl_cs_o), .fl_sck_o(fl_sck_o),
    .fl_io_o(fl_io_o), .fl_oe_o(fl_oe_o),
    .host_cs_i(host_cs_i), .host_sck_i(host_sck_i), .host_mosi_i(host_mosi_i),
    .host_miso_o(host_miso_o)
  );

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  //////////////////////////////////////////////////////////////////////
  // pad and device model

  function automatic logic [LANES-1:0] pad_model(input logic [LANES-1:0] oe,
                                                 input logic [LANES-1:0] out,
                                                 input logic loop,
                                                 input logic [LANES-1:0] dev);
    logic [LANES-1:0] p;
    p = dev;
    if (loop) p[LANE_MISO] = out[0];
    for (int k = 0; k < LANES; k++) begin
      if (oe[k]) p[k] = out[k];  // driven lanes read back the pad
    end
    return p;
  endfunction

  // device steps to its second nibble after the first sck high cycle
  always @(posedge pclk) begin
    if (dev_clr) dev_idx <= 1'b0;
    else if (eve_sck_o || fl_sck_o) dev_idx <= 1'b1;
  end

  assign dev_nib  = dev_idx ? dev_byte[3:0] : dev_byte[7:4];
  assign eve_io_i = pad_model(eve_oe_o, eve_io_o, loop_en, dev_nib);
  assign fl_io_i  = pad_model(fl_oe_o, fl_io_o, loop_en, dev_nib);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // rx expected after a transfer
  function automatic logic [IO_W-1:0] expected_rx(input logic quad, input logic dir,
                                                  input logic wide, input logic [IO_W-1:0] tx,
                                                  input logic [7:0] dev);
    if (quad && dir) return {tx[15:8], dev};
    if (wide) return {tx[7:0], tx[15:8]};
    return tx;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string what, input logic [IO_W-1:0] got,
                            input logic [IO_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_pins(input string what, input logic cs, input logic sck,
                            input logic [LANES-1:0] io, input logic [LANES-1:0] oe,
                            input logic cs_e, input logic sck_e,
                            input logic [LANES-1:0] io_e, input logic [LANES-1:0] oe_e);
    if ({cs, sck, io, oe} !== {cs_e, sck_e, io_e, oe_e})
      abort_run($sformatf("MISMATCH at %0t: %s cs/sck/io/oe got %b %b %b %b expected %b %b %b %b",
                          $time, what, cs, sck, io, oe, cs_e, sck_e, io_e, oe_e));
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus access

  task automatic bus_write(input logic [IO_ADDR_W-1:0] addr, input logic [IO_W-1:0] data);
    @(posedge pclk);
    #2;
    io_a_i  = addr;
    io_wd_i = data;
    io_w_i  = 1'b1;
    @(posedge pclk);
    #2;
    io_w_i  = 1'b0;
  endtask

  task automatic bus_read(input logic [IO_ADDR_W-1:0] addr, output logic [IO_W-1:0] data);
    @(posedge pclk);
    #2;
    io_a_i = addr;
    io_r_i = 1'b1;
    @(negedge pclk);
    data = io_rd_o;
    @(posedge pclk);
    #2;
    io_r_i = 1'b0;
  endtask

  function automatic logic [IO_ADDR_W-1:0] reg_addr(input logic tgt, input io_addr_e a);
    return a + (tgt ? 12'h010 : 12'h000);  // flash block sits 0x10 above
  endfunction

  task automatic run_xfer(input logic tgt, input logic quad, input logic dir, input logic wide,
                          input logic [IO_W-1:0] tx, input logic [IO_W-1:0] exp_rx,
                          input logic [IO_W-1:0] exp_cyc);
    logic [IO_W-1:0] rd;
    int busy;
    int guard;
    logic done;
    bus_write(reg_addr(tgt, A_EVE_QUAD), {15'd0, quad});
    bus_write(reg_addr(tgt, A_EVE_DIR), {15'd0, dir});
    loop_en = !quad;
    dev_clr = 1'b1;
    bus_write(reg_addr(tgt, wide ? A_EVE_X16 : A_EVE_X8), tx);
    dev_clr = 1'b0;
    io_a_i  = reg_addr(tgt, A_EVE_STAT);
    io_r_i  = 1'b1;
    busy  = 0;
    guard = 0;
    done  = 1'b0;
    while (!done && guard < POLL_MAX) begin
      @(negedge pclk);
      if (io_rd_o[0]) done = 1'b1;
      else busy++;
      guard++;
    end
    if (!done) abort_run("transfer never returned to idle within the poll limit");
    @(posedge pclk);
    #2;
    io_r_i = 1'b0;
    check_word("busy cycles", 16'(busy), exp_cyc);
    bus_read(reg_addr(tgt, A_EVE_X8), rd);
    check_word("rx data", rd, exp_rx);
    dev_clr = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int rec;
    logic running;
    logic [3:0] kind;
    logic tgt, quad, dir, wide;
    logic [IO_W-1:0] data, exp, cyc, rd, tx;
    logic [7:0] dev;
    SCKclock = 1'b1;
    io_a_i = '0;
    io_wd_i = '0;
    io_r_i = 1'b0;
    io_w_i = 1'b0;
    host_cs_i = 1'b0;
    host_sck_i = 1'b0;
    host_mosi_i = 1'b0;
    loop_en = 1'b0;
    dev_byte = 8'h00;
    dev_clr = 1'b1;
    lcg_state = 32'd45581;
    $readmemh("dv/spi_bridge_stim.txt", stim_mem);
    repeat (5) @(posedge pclk);
    #2 SCKclock = 1'b0;
    rec = 0;
    running = 1'b1;
    while (running) begin
      @(posedge pclk);
      #2;
      kind = stim_mem[rec*REC_W+0][3:0];
      tgt  = stim_mem[rec*REC_W+1][0];
      quad = stim_mem[rec*REC_W+2][0];
      dir  = stim_mem[rec*REC_W+3][0];
      wide = stim_mem[rec*REC_W+4][0];
      data = stim_mem[rec*REC_W+5][15:0];
      dev  = stim_mem[rec*REC_W+6][7:0];
      exp  = stim_mem[rec*REC_W+7][15:0];
      cyc  = stim_mem[rec*REC_W+8][15:0];
      dev_byte = dev;
      case (kind)
        4'h0: begin  // state right after reset
          bus_read(A_EVE_STAT, rd);
          check_word("eve stat", rd, 16'h0001);
          bus_read(A_FL_STAT, rd);
          check_word("flash stat", rd, 16'h0001);
          check_pins("eve reset", eve_cs_o, eve_sck_o, eve_io_o, eve_oe_o,
                     1'b1, 1'b0, 4'b0000, 4'b1101);
          check_pins("flash reset", fl_cs_o, fl_sck_o, fl_io_o, fl_oe_o,
                     1'b1, 1'b0, 4'b0000, 4'b1101);
          check_bit("eve_pd", eve_pd_o, 1'b0);
          check_bit("host_miso", host_miso_o, 1'b0);
        end
        4'h1: run_xfer(tgt, quad, dir, wide, data, exp, cyc);
        4'h2: begin
          lcg_state = lcg_next(lcg_state);
          tx = lcg_state[31:16];
          run_xfer(tgt, quad, dir, wide, tx, expected_rx(quad, dir, wide, tx, dev), cyc);
        end
        4'h3: begin  // host drives the eve pins
          loop_en = 1'b0;
          bus_write(A_MUX, 16'h0001);
          host_cs_i   = data[2];
          host_sck_i  = data[1];
          host_mosi_i = data[0];
          @(negedge pclk);
          check_pins("eve host", eve_cs_o, eve_sck_o, eve_io_o, eve_oe_o,
                     data[2], data[1], {3'b000, data[0]}, 4'b1101);
          check_bit("host_miso", host_miso_o, exp[0]);
          check_pins("flash static", fl_cs_o, fl_sck_o, fl_io_o, fl_oe_o,
                     1'b1, 1'b0, 4'b0000, 4'b1101);
        end
        4'h4: begin
          loop_en = 1'b0;
          bus_write(reg_addr(tgt, A_EVE_PINS), data);
          @(negedge pclk);
          if (tgt) check_pins("flash pins", fl_cs_o, fl_sck_o, fl_io_o, fl_oe_o,
                              data[5], data[4], data[3:0], 4'b1101);
          else check_pins("eve pins", eve_cs_o, eve_sck_o, eve_io_o, eve_oe_o,
                          data[5], data[4], data[3:0], 4'b1101);
          bus_read(reg_addr(tgt, A_EVE_PINS), rd);
          check_word("pins read", rd, exp);
        end
        4'h5: begin
          bus_write(A_SYSCTL, data);
          @(negedge pclk);
          check_bit("eve_pd", eve_pd_o, exp[0]);
        end
        4'h6: begin
          loop_en = 1'b0;
          host_cs_i   = 1'b0;
          host_sck_i  = 1'b0;
          host_mosi_i = 1'b0;
          bus_write(A_MUX, data);
          @(negedge pclk);
          check_bit("host_miso", host_miso_o, exp[0]);
        end
        4'hf: running = 1'b0;
        default: abort_run("stim file holds an unknown record kind");
      endcase
      rec++;
      if (running && rec >= MAX_REC) abort_run("stim file has no end record");
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    #(RUN_LIMIT);
    abort_run("simulation ran past its time limit");
  end

endmodule

`default_nettype wire

// ==== files.f ====
logic/spi_bridge_pkg.sv
logic/spi_engine.sv
logic/spi_pin_mux.sv
logic/io_regs.sv
logic/spi_bridge_top.sv
dv/spi_bridge_props.sv
dv/spi_bridge_tb.sv

// ==== logic/io_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module io_regs
  import spi_bridge_pkg::*;
(
  input  logic                 pclk,
  input  logic                 SCKclock,
  input  logic [IO_ADDR_W-1:0] io_a_i,
  input  logic [IO_W-1:0]      io_wd_i,
  input  logic                 io_r_i,
  input  logic                 io_w_i,
  output logic [IO_W-1:0]      io_rd_o,

  // display controller side
  input  logic [IO_W-1:0]      eve_rx_i,
  input  logic                 eve_idle_i,
  input  logic [LANES-1:0]     eve_pad_i,
  output logic                 eve_start8_o,
  output logic                 eve_start16_o,
  output logic                 eve_dir_o,
  output lane_mode_e           eve_quad_o,
  output logic [PIN_W-1:0]     eve_static_o,

  // flash side
  input  logic [IO_W-1:0]      fl_rx_i,
  input  logic                 fl_idle_i,
  input  logic [LANES-1:0]     fl_pad_i,
  output logic                 fl_start8_o,
  output logic                 fl_start16_o,
  output logic                 fl_dir_o,
  output lane_mode_e           fl_quad_o,
  output logic [PIN_W-1:0]     fl_static_o,

  output logic [1:0]           mux_o,
  output logic                 eve_pd_o
);

  logic [IO_W-1:0] rd_data;

  //////////////////////////////////////////////////////////////////////
  // start strobes in the same cycle as the write

  assign eve_start8_o  = io_w_i && (io_a_i == A_EVE_X8);
  assign eve_start16_o = io_w_i && (io_a_i == A_EVE_X16);
  assign fl_start8_o   = io_w_i && (io_a_i == A_FL_X8);
  assign fl_start16_o  = io_w_i && (io_a_i == A_FL_X16);

  //////////////////////////////////////////////////////////////////////
  // control registers

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      mux_o        <= '0;
      eve_pd_o     <= 1'b0;
      eve_static_o <= PIN_RESET;
      eve_dir_o    <= 1'b0;
      eve_quad_o   <= MODE_SINGLE;
      fl_static_o  <= PIN_RESET;
      fl_dir_o     <= 1'b0;
      fl_quad_o    <= MODE_SINGLE;
    end else if (io_w_i) begin
      case (io_a_i)
        A_MUX:      mux_o        <= io_wd_i[1:0];
        A_SYSCTL:   eve_pd_o     <= io_wd_i[0];  // display power-down
        A_EVE_PINS: eve_static_o <= io_wd_i[PIN_W-1:0];
        A_EVE_DIR:  eve_dir_o    <= io_wd_i[0];
        A_EVE_QUAD: eve_quad_o   <= lane_mode_e'(io_wd_i[0]);
        A_FL_PINS:  fl_static_o  <= io_wd_i[PIN_W-1:0];
        A_FL_DIR:   fl_dir_o     <= io_wd_i[0];
        A_FL_QUAD:  fl_quad_o    <= lane_mode_e'(io_wd_i[0]);
        default: ;  // x8/x16 go straight to the engines
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read data

  always_comb begin
    rd_data = '0;  // unmapped addresses read zero
    case (io_a_i)
      A_MUX:      rd_data = {{(IO_W-2){1'b0}}, mux_o};
      A_SYSCTL:   rd_data = {{(IO_W-1){1'b0}}, eve_pd_o};

      // pins read back the pads, not the static levels
      A_EVE_PINS: rd_data = {{(IO_W-LANES){1'b0}}, eve_pad_i};
      A_EVE_X8:   rd_data = eve_rx_i;
      A_EVE_X16:  rd_data = eve_rx_i;
      A_EVE_STAT: rd_data = {{(IO_W-1){1'b0}}, eve_idle_i};
      A_EVE_DIR:  rd_data = {{(IO_W-1){1'b0}}, eve_dir_o};
      A_EVE_QUAD: rd_data = {{(IO_W-1){1'b0}}, eve_quad_o};

      A_FL_PINS:  rd_data = {{(IO_W-LANES){1'b0}}, fl_pad_i};
      A_FL_X8:    rd_data = fl_rx_i;
      A_FL_X16:   rd_data = fl_rx_i;
      A_FL_STAT:  rd_data = {{(IO_W-1){1'b0}}, fl_idle_i};
      A_FL_DIR:   rd_data = {{(IO_W-1){1'b0}}, fl_dir_o};
      A_FL_QUAD:  rd_data = {{(IO_W-1){1'b0}}, fl_quad_o};
      default:    rd_data = '0;
    endcase
  end

  // data is only presented while the read strobe is up
  assign io_rd_o = io_r_i ? rd_data : '0;

endmodule

`default_nettype wire

// ==== logic/spi_bridge_pkg.sv ====
`default_nettype none

package spi_bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus and pin widths

  localparam int IO_W      = 16;  // cpu i/o data
  localparam int IO_ADDR_W = 12;  // decoded part of the i/o address
  localparam int LANES     = 4;   // io0..io3 per target
  localparam int PIN_W     = 6;   // cs, sck and the four lanes
  localparam int CNT_W     = 5;   // engine bit counter

  // pin vector layout from the msb down is cs sck io3 io2 miso mosi
  localparam int PIN_CS    = 5;
  localparam int PIN_SCK   = 4;
  localparam int LANE_MISO = 1;

  //////////////////////////////////////////////////////////////////////
  // reset and engine constants

  localparam logic [PIN_W-1:0] PIN_RESET   = 6'b100000;  // cs high and the rest low
  localparam logic [CNT_W-1:0] CNT_START8  = 5'd16;      // half a lap
  localparam logic [CNT_W-1:0] CNT_START16 = 5'd0;       // full lap
  localparam logic [CNT_W-1:0] STEP_SINGLE = 5'd1;
  localparam logic [CNT_W-1:0] STEP_QUAD   = 5'd4;
  localparam logic [LANES-1:0] MASK_SINGLE = 4'b0010;    // only miso is an input

  //////////////////////////////////////////////////////////////////////
  // register map

  typedef enum logic [IO_ADDR_W-1:0] {
    A_MUX      = 12'h011,  // host passthrough select
    A_SYSCTL   = 12'h014,
    A_EVE_PINS = 12'h100,
    A_EVE_X8   = 12'h101,
    A_EVE_X16  = 12'h102,
    A_EVE_STAT = 12'h103,
    A_EVE_DIR  = 12'h104,
    A_EVE_QUAD = 12'h105,
    A_FL_PINS  = 12'h110,
    A_FL_X8    = 12'h111,
    A_FL_X16   = 12'h112,
    A_FL_STAT  = 12'h113,
    A_FL_DIR   = 12'h114,
    A_FL_QUAD  = 12'h115
  } io_addr_e;

  typedef enum logic {
    SPI_IDLE = 1'b0,
    SPI_RUN  = 1'b1
  } spi_state_e;

  typedef enum logic {
    MODE_SINGLE = 1'b0,
    MODE_QUAD   = 1'b1
  } lane_mode_e;

endpackage

`default_nettype wire

// ==== logic/spi_bridge_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_bridge_top
  import spi_bridge_pkg::*;
(
  input  logic                 pclk,
  input  logic                 SCKclock,

  // cpu i/o bus
  input  logic [IO_ADDR_W-1:0] io_a_i,
  input  logic [IO_W-1:0]      io_wd_i,
  input  logic                 io_r_i,
  input  logic                 io_w_i,
  output logic [IO_W-1:0]      io_rd_o,

  // display controller pads
  input  logic [LANES-1:0]     eve_io_i,
  output logic                 eve_cs_o,
  output logic                 eve_sck_o,
  output logic [LANES-1:0]     eve_io_o,
  output logic [LANES-1:0]     eve_oe_o,
  output logic                 eve_pd_o,

  // flash pads
  input  logic [LANES-1:0]     fl_io_i,
  output logic                 fl_cs_o,
  output logic                 fl_sck_o,
  output logic [LANES-1:0]     fl_io_o,
  output logic [LANES-1:0]     fl_oe_o,

  // external host passthrough
  input  logic                 host_cs_i,
  input  logic                 host_sck_i,
  input  logic                 host_mosi_i,
  output logic                 host_miso_o
);

  logic [IO_W-1:0]  eve_rx, fl_rx;
  logic             eve_idle, fl_idle;
  logic             eve_start8, eve_start16, fl_start8, fl_start16;
  logic             eve_dir, fl_dir;
  lane_mode_e       eve_quad, fl_quad;
  logic [PIN_W-1:0] eve_static, fl_static;
  logic [PIN_W-1:0] eve_eng_pins, fl_eng_pins;
  logic [LANES-1:0] eve_mask, fl_mask;
  logic [1:0]       mux;

  io_regs u_regs (
    .pclk          (pclk),
    .SCKclock      (SCKclock),
    .io_a_i        (io_a_i),
    .io_wd_i       (io_wd_i),
    .io_r_i        (io_r_i),
    .io_w_i        (io_w_i),
    .io_rd_o       (io_rd_o),
    .eve_rx_i      (eve_rx),
    .eve_idle_i    (eve_idle),
    .eve_pad_i     (eve_io_i),
    .eve_start8_o  (eve_start8),
    .eve_start16_o (eve_start16),
    .eve_dir_o     (eve_dir),
    .eve_quad_o    (eve_quad),
    .eve_static_o  (eve_static),
    .fl_rx_i       (fl_rx),
    .fl_idle_i     (fl_idle),
    .fl_pad_i      (fl_io_i),
    .fl_start8_o   (fl_start8),
    .fl_start16_o  (fl_start16),
    .fl_dir_o      (fl_dir),
    .fl_quad_o     (fl_quad),
    .fl_static_o   (fl_static),
    .mux_o         (mux),
    .eve_pd_o      (eve_pd_o)
  );

  //////////////////////////////////////////////////////////////////////
  // display controller path

  spi_engine u_eve_eng (
    .pclk      (pclk),
    .SCKclock  (SCKclock),
    .start8_i  (eve_start8),
    .start16_i (eve_start16),
    .tx_i      (io_wd_i),  // tx rides on the write data
    .dir_i     (eve_dir),
    .quad_i    (eve_quad),
    .lanes_i   (eve_io_i),
    .rx_o      (eve_rx),
    .idle_o    (eve_idle),
    .pins_o    (eve_eng_pins),
    .mask_o    (eve_mask)
  );

  spi_pin_mux u_eve_mux (
    .host_sel_i  (mux[0]),
    .static_i    (eve_static),
    .engine_i    (eve_eng_pins),
    .mask_i      (eve_mask),
    .host_cs_i   (host_cs_i),
    .host_sck_i  (host_sck_i),
    .host_mosi_i (host_mosi_i),
    .cs_o        (eve_cs_o),
    .sck_o       (eve_sck_o),
    .io_o        (eve_io_o),
    .oe_o        (eve_oe_o)
  );

  //////////////////////////////////////////////////////////////////////
  // flash path

  spi_engine u_fl_eng (
    .pclk      (pclk),
    .SCKclock  (SCKclock),
    .start8_i  (fl_start8),
    .start16_i (fl_start16),
    .tx_i      (io_wd_i),
    .dir_i     (fl_dir),
    .quad_i    (fl_quad),
    .lanes_i   (fl_io_i),
    .rx_o      (fl_rx),
    .idle_o    (fl_idle),
    .pins_o    (fl_eng_pins),
    .mask_o    (fl_mask)
  );

  spi_pin_mux u_fl_mux (
    .host_sel_i  (mux[1]),
    .static_i    (fl_static),
    .engine_i    (fl_eng_pins),
    .mask_i      (fl_mask),
    .host_cs_i   (host_cs_i),
    .host_sck_i  (host_sck_i),
    .host_mosi_i (host_mosi_i),
    .cs_o        (fl_cs_o),
    .sck_o       (fl_sck_o),
    .io_o        (fl_io_o),
    .oe_o        (fl_oe_o)
  );

  // miso back to the host only when exactly one target is routed
  always_comb begin
    case (mux)
      2'b01:   host_miso_o = eve_io_i[LANE_MISO];
      2'b10:   host_miso_o = fl_io_i[LANE_MISO];
      default: host_miso_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/spi_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_engine
  import spi_bridge_pkg::*;
(
  input  logic             pclk,
  input  logic             SCKclock,
  input  logic             start8_i,
  input  logic             start16_i,
  input  logic [IO_W-1:0]  tx_i,
  input  logic             dir_i,
  input  lane_mode_e       quad_i,
  input  logic [LANES-1:0] lanes_i,
  output logic [IO_W-1:0]  rx_o,
  output logic             idle_o,
  output logic [PIN_W-1:0] pins_o,
  output logic [LANES-1:0] mask_o
);

  spi_state_e       state;
  logic [CNT_W-1:0] count;
  logic [IO_W-1:0]  shifter;

  logic             is_quad;
  logic             sck;
  logic [CNT_W-1:0] count_nxt;
  logic [IO_W-1:0]  tx_swap;

  assign is_quad   = (quad_i == MODE_QUAD);
  assign count_nxt = count + (is_quad ? STEP_QUAD : STEP_SINGLE);
  assign tx_swap   = {tx_i[7:0], tx_i[15:8]};  // low byte leaves first

  // sck toggles every count step in single mode, every 4 in quad
  assign sck = is_quad ? count[2] : count[0];

  //////////////////////////////////////////////////////////////////////
  // state, counter and shifter

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      state   <= SPI_IDLE;
      count   <= '0;
      shifter <= '0;
    end else if (start8_i || start16_i) begin
      // a new start also cuts a running transfer short
      state   <= SPI_RUN;
      count   <= start8_i ? CNT_START8 : CNT_START16;
      shifter <= tx_swap;
    end else if (state == SPI_RUN) begin
      count <= count_nxt;
      if (count_nxt == '0) begin
        state <= SPI_IDLE;  // counter wrapped
      end
      if (sck) begin
        if (is_quad) begin
          shifter <= {shifter[IO_W-LANES-1:0], lanes_i};
        end else begin
          shifter <= {shifter[IO_W-2:0], lanes_i[LANE_MISO]};
        end
      end
    end
  end

  assign rx_o   = shifter;
  assign idle_o = (state == SPI_IDLE);

  //////////////////////////////////////////////////////////////////////
  // pin levels and lane mask

  always_comb begin
    pins_o          = '0;  // cs stays with the static register
    pins_o[PIN_SCK] = sck;
    if (is_quad) begin
      pins_o[LANES-1:0] = shifter[IO_W-1 -: LANES];  // top nibble
    end else begin
      pins_o[0] = shifter[IO_W-1];  // msb on mosi
    end
  end

  assign mask_o = is_quad ? {LANES{dir_i}} : MASK_SINGLE;

endmodule

`default_nettype wire

// ==== logic/spi_pin_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

// one per target between the engine and the pads
module spi_pin_mux
  import spi_bridge_pkg::*;
(
  input  logic             host_sel_i,
  input  logic [PIN_W-1:0] static_i,
  input  logic [PIN_W-1:0] engine_i,
  input  logic [LANES-1:0] mask_i,
  input  logic             host_cs_i,
  input  logic             host_sck_i,
  input  logic             host_mosi_i,
  output logic             cs_o,
  output logic             sck_o,
  output logic [LANES-1:0] io_o,
  output logic [LANES-1:0] oe_o
);

  logic [PIN_W-1:0] levels;
  logic [PIN_W-1:0] host_pins;

  // host only drives cs, sck and mosi
  always_comb begin
    host_pins          = '0;
    host_pins[PIN_CS]  = host_cs_i;
    host_pins[PIN_SCK] = host_sck_i;
    host_pins[0]       = host_mosi_i;
  end

  //////////////////////////////////////////////////////////////////////
  // level select

  always_comb begin
    if (host_sel_i) begin
      levels = host_pins;
    end else begin
      levels = static_i | engine_i;  // engine bits ride on top of static
    end
  end

  assign cs_o  = levels[PIN_CS];
  assign sck_o = levels[PIN_SCK];
  assign io_o  = levels[LANES-1:0];

  // mask bit set means the lane is an input
  assign oe_o = ~mask_i;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the spi bridge testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module spi_bridge_tb \
  -f files.f \
  -o spi_bridge_sim

./obj_dir/spi_bridge_sim
